//--- tachTrace.txt
# sensorA sensorB clear hold expPulseA expPulseB expDrift expStatus
# status 0 balanced, 1 A leads, 2 B leads; holds below 6 run as 6 cycles
0 0 0 6 0 0 0 0
# channel A alone, toggles after the 4th and 8th edge
1 0 0 6 0 0 0 0
0 0 0 6 0 0 0 0
1 0 0 6 0 0 0 0
0 0 0 6 0 0 0 0
1 0 0 8 0 0 0 0
0 0 0 6 0 0 0 0
1 0 0 6 1 0 1 0
0 0 0 6 1 0 1 0
1 0 0 6 1 0 1 0
0 0 0 6 1 0 1 0
1 0 0 6 1 0 1 0
0 0 0 4 1 0 1 0
1 0 0 6 1 0 1 0
0 0 0 6 1 0 1 0
1 0 0 6 0 0 2 0
0 0 0 6 0 0 2 0
# both channels together, toggles in the same cycle
1 1 0 6 0 0 2 0
0 0 0 6 0 0 2 0
1 1 0 6 0 0 2 0
0 0 0 6 0 0 2 0
1 1 0 10 0 0 2 0
0 0 0 6 0 0 2 0
1 1 0 6 1 1 2 0
0 0 0 6 1 1 2 0
# A pulls ahead, B gets 3 edges without a toggle
1 1 0 6 1 1 2 0
0 0 0 6 1 1 2 0
1 1 0 6 1 1 2 0
0 0 0 6 1 1 2 0
1 1 0 6 1 1 2 0
0 0 0 6 1 1 2 0
1 0 0 6 0 1 3 1
0 0 0 6 0 1 3 1
1 0 0 6 0 1 3 1
0 0 0 6 0 1 3 1
1 0 0 6 0 1 3 1
0 0 0 6 0 1 3 1
1 0 0 6 0 1 3 1
0 0 0 6 0 1 3 1
1 0 0 6 1 1 4 1
0 0 0 6 1 1 4 1
1 0 0 6 1 1 4 1
0 0 0 6 1 1 4 1
1 0 0 6 1 1 4 1
0 0 0 8 1 1 4 1
1 0 0 6 1 1 4 1
0 0 0 6 1 1 4 1
1 0 0 6 0 1 5 1
0 0 0 6 0 1 5 1
1 0 0 6 0 1 5 1
0 0 0 6 0 1 5 1
1 0 0 6 0 1 5 1
0 0 0 6 0 1 5 1
1 0 0 6 0 1 5 1
0 0 0 6 0 1 5 1
1 0 0 6 1 1 6 1
0 0 0 6 1 1 6 1
1 0 0 6 1 1 6 1
0 0 0 6 1 1 6 1
1 0 0 6 1 1 6 1
0 0 0 6 1 1 6 1
1 0 0 6 1 1 6 1
0 0 0 6 1 1 6 1
1 0 0 6 0 1 7 1
0 0 0 6 0 1 7 1
# saturated, one more A toggle keeps 7
1 0 0 6 0 1 7 1
0 0 0 6 0 1 7 1
1 0 0 6 0 1 7 1
0 0 0 6 0 1 7 1
1 0 0 6 0 1 7 1
0 0 0 6 0 1 7 1
1 0 0 6 1 1 7 1
# clear strobe, pulse levels kept
0 0 1 6 1 1 0 0
# B ahead, first toggle needs one edge
0 1 0 6 1 0 -1 0
0 0 0 6 1 0 -1 0
0 1 0 6 1 0 -1 0
0 0 0 6 1 0 -1 0
0 1 0 6 1 0 -1 0
0 0 0 6 1 0 -1 0
0 1 0 6 1 0 -1 0
0 0 0 6 1 0 -1 0
0 1 0 6 1 1 -2 0
0 0 0 6 1 1 -2 0
0 1 0 6 1 1 -2 0
0 0 0 6 1 1 -2 0
0 1 0 6 1 1 -2 0
0 0 0 6 1 1 -2 0
0 1 0 6 1 1 -2 0
0 0 0 6 1 1 -2 0
0 1 0 6 1 0 -3 2
0 0 0 6 1 0 -3 2

//--- list.f
tachPkg.sv
edgeDivider.sv
driftMonitor.sv
tachDividerTop.sv
tachDividerTb.sv

//--- run.sh
#!/usr/bin/env bash
# build and run the tachometer divider testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tachDividerTb -f list.f -o tachSim

# a fatal check ends the simulator with a nonzero status
output="$(./obj_dir/tachSim 2>&1)" || true
echo "$output"

if grep -q "All checks passed" <<< "$output"
then
    echo "PASS"
    exit 0
else
    echo "FAIL"
    exit 1
fi

//--- tachDividerTb.sv
//----------------------------------------
// testbench for the tachometer divider
// replays the stimulus trace, holds each
// step until the pipelines settle, then
// compares pulses, drift and status
//----------------------------------------
`default_nettype none

module tachDividerTb;

    timeunit 1ns;
    timeprecision 100ps;

    //----------------------------------------
    // DUT signals
    //----------------------------------------
    logic                                  iCLK;
    logic                                  iRST;
    logic                                  sensorA;
    logic                                  sensorB;
    logic                                  clear;
    logic                                  pulseA;
    logic                                  pulseB;
    logic signed [tachPkg::cDriftBits-1:0] drift;
    tachPkg::driftStatus_t                 status;

    //----------------------------------------
    // trace storage and run control
    //----------------------------------------
    // one entry per trace step
    int stepA[$];
    int stepB[$];
    int stepClr[$];
    int stepHold[$];
    int expA[$];
    int expB[$];
    int expDrift[$];
    int expStatus[$];

    // posedges since time zero
    int cycleCount = 0;
    // stays zero until the trace is loaded
    int cycleLimit = 0;

    tachDividerTop tachDividerTop_i
    (
        .iCLK    (iCLK),
        .iRST    (iRST),
        .sensorA (sensorA),
        .sensorB (sensorB),
        .clear   (clear),
        .pulseA  (pulseA),
        .pulseB  (pulseB),
        .drift   (drift),
        .status  (status)
    );

    // 10 ns period
    initial
    begin
        iCLK = 1'b0;
        forever
        begin
            #5 iCLK = ~iCLK;
        end
    end

    // watchdog
    always @(posedge iCLK)
    begin
        cycleCount = cycleCount + 1;
        if (cycleLimit > 0 && cycleCount >= cycleLimit)
        begin
            abortRun("timeout, the trace did not finish within the cycle limit");
        end
    end

    //----------------------------------------
    // helpers
    //----------------------------------------
    task automatic abortRun(input string why);
        $display("%s", why);
        $display("Checks failed");
        $fatal(1, "run stopped");
    endtask

    // short holds are stretched so all pipelines settle
    function automatic int effectiveHold(input int hold);
        return (hold < 6) ? 6 : hold;
    endfunction

    task automatic checkLevel(input string where, input logic act, input logic exp);
        if (act !== exp)
        begin
            abortRun($sformatf("Mismatch at %0d ns: %s is %b, expected %b",
                $time, where, act, exp));
        end
    endtask

    task automatic checkDrift(input string where,
        input logic signed [tachPkg::cDriftBits-1:0] act,
        input logic signed [tachPkg::cDriftBits-1:0] exp);
        if (act !== exp)
        begin
            abortRun($sformatf("Mismatch at %0d ns: %s is %0d, expected %0d",
                $time, where, act, exp));
        end
    endtask

    task automatic checkStatus(input string where,
        input tachPkg::driftStatus_t act, input tachPkg::driftStatus_t exp);
        if (act !== exp)
        begin
            abortRun($sformatf("Mismatch at %0d ns: %s is %s, expected %s",
                $time, where, act.name(), exp.name()));
        end
    endtask

    // comment and blank lines scan as zero fields
    task automatic readTrace();
        int    fd;
        int    n;
        int    f[8];
        string line;
        fd = $fopen("tachTrace.txt", "r");
        if (fd == 0)
        begin
            abortRun("cannot open the trace file tachTrace.txt");
        end
        while (!$feof(fd))
        begin
            line = "";
            void'($fgets(line, fd));
            n = $sscanf(line, "%d %d %d %d %d %d %d %d",
                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7]);
            if (n == 8)
            begin
                stepA.push_back(f[0]);
                stepB.push_back(f[1]);
                stepClr.push_back(f[2]);
                stepHold.push_back(f[3]);
                expA.push_back(f[4]);
                expB.push_back(f[5]);
                expDrift.push_back(f[6]);
                expStatus.push_back(f[7]);
            end
            else if (n > 0)
            begin
                abortRun("the trace file holds a line with missing fields");
            end
        end
        $fclose(fd);
    endtask

    // entered 1 ns after a posedge, leaves at the same phase
    task automatic applyStep(input int idx);
        int hold;
        hold    = effectiveHold(stepHold[idx]);
        sensorA = (stepA[idx] != 0);
        sensorB = (stepB[idx] != 0);
        clear   = (stepClr[idx] != 0);
        repeat (hold)
        begin
            @(posedge iCLK);
            #1;
            // clear is a one-cycle strobe
            clear = 1'b0;
        end
    endtask

    task automatic compareStep(input int idx);
        string tag;
        tag = $sformatf("step %0d", idx + 1);
        checkLevel({tag, " pulseA"}, pulseA, expA[idx] != 0);
        checkLevel({tag, " pulseB"}, pulseB, expB[idx] != 0);
        checkDrift({tag, " drift"}, drift, (tachPkg::cDriftBits)'(expDrift[idx]));
        checkStatus({tag, " status"}, status, tachPkg::driftStatus_t'(expStatus[idx]));
    endtask

    //----------------------------------------
    // main sequence
    //----------------------------------------
    initial
    begin
        iRST    = 1'b1;
        sensorA = 1'b0;
        sensorB = 1'b0;
        clear   = 1'b0;
        readTrace();
        if (stepA.size() == 0)
        begin
            abortRun("the trace file holds no steps");
        end
        // reset, all holds, margin
        cycleLimit = 16 + 100;
        foreach (stepHold[i])
        begin
            cycleLimit = cycleLimit + effectiveHold(stepHold[i]);
        end
        repeat (16) @(posedge iCLK);
        #1;
        iRST = 1'b0;
        // reset values straight from the package
        checkLevel("after reset pulseA", pulseA, tachPkg::cStartLevel);
        checkLevel("after reset pulseB", pulseB, tachPkg::cStartLevel);
        checkDrift("after reset drift", drift, '0);
        checkStatus("after reset status", status, tachPkg::stBalanced);
        for (int i = 0; i < stepA.size(); i++)
        begin
            applyStep(i);
            compareStep(i);
        end
        $display("All checks passed");
        $finish;
    end

endmodule

`default_nettype wire

//--- tachDividerTop.sv
//----------------------------------------
// dual-channel tachometer divider
// two independent edge dividers and one
// drift monitor comparing their outputs
//----------------------------------------
`default_nettype none

module tachDividerTop
(
    input  logic                                iCLK,
    input  logic                                iRST,
    input  logic                                sensorA,
    input  logic                                sensorB,
    input  logic                                clear,
    output logic                                pulseA,
    output logic                                pulseB,
    output logic signed [tachPkg::cDriftBits-1:0] drift,
    output tachPkg::driftStatus_t               status
);

    //----------------------------------------
    // channel dividers
    //----------------------------------------
    // sensor edge to pulse is 2 cycles
    // the channels share no logic
    edgeDivider chanA_i
    (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .sensor (sensorA),
        .pulse  (pulseA)
    );

    edgeDivider chanB_i
    (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .sensor (sensorB),
        .pulse  (pulseB)
    );

    //----------------------------------------
    // drift monitor
    //----------------------------------------
    // divided levels feed both the ports and the monitor
    // drift one cycle after a toggle, status one more
    driftMonitor driftMonitor_i
    (
        .iCLK   (iCLK),
        .iRST   (iRST),
        .pulseA (pulseA),
        .pulseB (pulseB),
        .clear  (clear),
        .drift  (drift),
        .status (status)
    );

endmodule

`default_nettype wire

//--- driftMonitor.sv
//----------------------------------------
// drift monitor for two divided channels
// counts toggles on A minus toggles on B
// with saturation, reports which channel
// leads, clear strobe zeroes the count
//----------------------------------------
`default_nettype none

module driftMonitor
(
    input  logic                                iCLK,
    input  logic                                iRST,
    input  logic                                pulseA,
    input  logic                                pulseB,
    input  logic                                clear,
    output logic signed [tachPkg::cDriftBits-1:0] drift,
    output tachPkg::driftStatus_t               status
);

    //----------------------------------------
    // signals
    //----------------------------------------
    // pulse levels of the previous cycle
    logic                  prevA;
    logic                  prevB;
    // level change seen this cycle
    logic                  togA;
    logic                  togB;
    // net step direction
    logic                  stepUp;
    logic                  stepDown;
    // saturation reached
    logic                  atMax;
    logic                  atMin;
    // classification of the current count
    tachPkg::driftStatus_t statusNext;

    //----------------------------------------
    // toggle detection
    //----------------------------------------
    // history starts at the divider reset level
    // so no false toggle right after reset
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            prevA <= tachPkg::cStartLevel;
            prevB <= tachPkg::cStartLevel;
        end
        else
        begin
            prevA <= pulseA;
            prevB <= pulseB;
        end
    end

    always_comb
    begin
        togA     = pulseA ^ prevA;
        togB     = pulseB ^ prevB;
        // both at once cancel out
        stepUp   = togA & ~togB;
        stepDown = togB & ~togA;
        atMax    = (drift >= tachPkg::cDriftMax);
        atMin    = (drift <= -tachPkg::cDriftMax);
    end

    //----------------------------------------
    // drift counter
    //----------------------------------------
    // clear has priority over any toggle
    // holds at the bound instead of wrapping
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            drift <= '0;
        end
        else if (clear)
        begin
            drift <= '0;
        end
        else if (stepUp && !atMax)
        begin
            drift <= drift + 1'b1;
        end
        else if (stepDown && !atMin)
        begin
            drift <= drift - 1'b1;
        end
    end

    //----------------------------------------
    // status classification
    //----------------------------------------
    // positive count means A ahead
    always_comb
    begin
        if (drift >= tachPkg::cDriftLimit)
        begin
            statusNext = tachPkg::stALead;
        end
        else if (drift <= -tachPkg::cDriftLimit)
        begin
            statusNext = tachPkg::stBLead;
        end
        else
        begin
            statusNext = tachPkg::stBalanced;
        end
    end

    // one cycle behind the count
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            status <= tachPkg::stBalanced;
        end
        else
        begin
            status <= statusNext;
        end
    end

    //----------------------------------------
    // assertions
    //----------------------------------------
    // count stays inside the saturation window
    aDriftRange : assert property (@(posedge iCLK) disable iff (iRST)
        (drift <= tachPkg::cDriftMax) && (drift >= -tachPkg::cDriftMax))
    else $error("driftMonitor: drift count out of range");

    // A lead only from a count at or above the limit
    aALeadValid : assert property (@(posedge iCLK) disable iff (iRST)
        (status == tachPkg::stALead) |-> ($past(drift) >= tachPkg::cDriftLimit))
    else $error("driftMonitor: stALead with count below limit");

endmodule

`default_nettype wire

//--- edgeDivider.sv
//----------------------------------------
// edge divider for one tachometer channel
// synchronizes the sensor level, finds
// rising edges and toggles the output
// once every cDivRatio edges
//----------------------------------------
`default_nettype none

module edgeDivider
(
    input  logic iCLK,
    input  logic iRST,
    input  logic sensor,
    output logic pulse
);

    //----------------------------------------
    // signals
    //----------------------------------------
    // bit 0 is the first sync stage, top bit is history
    logic [tachPkg::cSyncStages-1:0] syncSft;
    // one-cycle flag for a detected rising edge
    logic                            edgeSeen;
    // edges since the last toggle
    logic [tachPkg::cCntBits-1:0]    edgeCnt;
    // counter holds its final value
    logic                            cntLast;

    //----------------------------------------
    // input synchronizer
    //----------------------------------------
    // sensor is asynchronous
    // shift in every cycle, oldest bit drops out
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            syncSft <= '0;
        end
        else
        begin
            syncSft <= {syncSft[tachPkg::cSyncStages-2:0], sensor};
        end
    end

    //----------------------------------------
    // rising edge detect
    //----------------------------------------
    // oldest stage low, next one high
    // visible one cycle after the first sample
    always_comb
    begin
        edgeSeen = (syncSft[tachPkg::cSyncStages-1 -: 2] == 2'b01);
    end

    // last count before the wrap
    always_comb
    begin
        cntLast = (int'(edgeCnt) == tachPkg::cDivRatio - 1);
    end

    //----------------------------------------
    // edge counter
    //----------------------------------------
    // modulo cDivRatio
    // wraps to zero on the completing edge, so no edge is lost
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            edgeCnt <= '0;
        end
        else if (edgeSeen)
        begin
            if (cntLast)
            begin
                edgeCnt <= '0;
            end
            else
            begin
                edgeCnt <= edgeCnt + 1'b1;
            end
        end
    end

    //----------------------------------------
    // output toggle
    //----------------------------------------
    // flips together with the counter wrap
    always_ff @(posedge iCLK)
    begin
        if (iRST)
        begin
            pulse <= tachPkg::cStartLevel;
        end
        else if (edgeSeen && cntLast)
        begin
            pulse <= ~pulse;
        end
    end

    //----------------------------------------
    // assertions
    //----------------------------------------
    // counter must never hold the ratio itself
    aCntRange : assert property (@(posedge iCLK) disable iff (iRST)
        int'(edgeCnt) < tachPkg::cDivRatio)
    else $error("edgeDivider: edge count reached cDivRatio");

endmodule

`default_nettype wire

//--- tachPkg.sv
//----------------------------------------
// tachometer divider shared definitions
// divide ratio and counter widths for the
// edge dividers, drift limits and the
// monitor state encoding
//----------------------------------------
`default_nettype none

package tachPkg;

    //----------------------------------------
    // edge divider
    //----------------------------------------
    // input rising edges per output toggle
    // shared by both channels so drift stays meaningful
    localparam int cDivRatio = 4;

    // edge counter width, counts 0 .. cDivRatio-1
    localparam int cCntBits = $clog2(cDivRatio);

    // two sync stages plus one history stage
    localparam int cSyncStages = 3;

    // divided output level after reset
    localparam logic cStartLevel = 1'b0;

    //----------------------------------------
    // drift monitor
    //----------------------------------------
    // signed drift count width
    localparam int cDriftBits = 4;

    // count saturates at +/- this magnitude
    localparam int cDriftMax = 7;

    // lead reported at or beyond this magnitude
    localparam int cDriftLimit = 3;

    // monitor state, numeric values used by the trace
    typedef enum logic [1:0]
    {
        stBalanced = 2'd0,
        stALead    = 2'd1,
        stBLead    = 2'd2
    } driftStatus_t;

endpackage

`default_nettype wire
